//--- source/glb_cfg_pkg.sv
// global buffer configuration definitions
`default_nettype none

package glb_cfg_pkg;

    localparam int CFG_ADDR_WIDTH = 12;
    localparam int CFG_DATA_WIDTH = 32;
    localparam int TILE_ID_WIDTH = 4;
    localparam int GLB_ADDR_WIDTH = 16;
    localparam int MAX_NUM_WORDS_WIDTH = 8;
    localparam int BANK_DATA_WIDTH = 32;
    localparam int REG_IDX_WIDTH = 5;

    // address fields: tile id in [10:7], register index in [6:2]
    localparam int TILE_ID_LSB = 7;
    localparam int REG_IDX_LSB = 2;

    typedef logic [CFG_ADDR_WIDTH-1:0] cfg_addr_t;
    typedef logic [CFG_DATA_WIDTH-1:0] cfg_data_t;
    typedef logic [TILE_ID_WIDTH-1:0] tile_id_t;
    typedef logic [GLB_ADDR_WIDTH-1:0] glb_addr_t;
    typedef logic [MAX_NUM_WORDS_WIDTH-1:0] num_words_t;
    typedef logic [BANK_DATA_WIDTH-1:0] bank_data_t;
    typedef logic [REG_IDX_WIDTH-1:0] reg_idx_t;

    // control register, then two words per store header
    localparam reg_idx_t REG_CTRL = 5'd0;
    localparam reg_idx_t REG_HEADER_BASE = 5'd1;

    typedef struct packed {
        logic       valid;
        glb_addr_t  start_addr;
        num_words_t num_words;
    } dma_header_t;

    typedef struct packed {
        logic      wr_en;
        cfg_addr_t wr_addr;
        cfg_data_t wr_data;
        logic      rd_en;
        cfg_addr_t rd_addr;
    } cfg_req_t;

    typedef struct packed {
        logic      rd_data_valid;
        cfg_data_t rd_data;
    } cfg_rsp_t;

    typedef struct packed {
        logic       valid;
        bank_data_t data;
    } stream_t;

    typedef struct packed {
        logic       en;
        glb_addr_t  addr;
        bank_data_t data;
    } bank_wr_t;

endpackage

`default_nettype wire

//--- source/glb_cfg_wb_bridge.sv
// wishbone to configuration chain bridge
`timescale 1ns/100ps
`default_nettype none

module glb_cfg_wb_bridge #(
    parameter int NUM_TILES = 4
) (
    input  logic                   clk,
    input  logic                   reset,
    input  logic                   wb_cyc,
    input  logic                   wb_stb,
    input  logic                   wb_we,
    input  glb_cfg_pkg::cfg_addr_t wb_adr,
    input  glb_cfg_pkg::cfg_data_t wb_dat_w,
    output logic                   wb_ack,
    output glb_cfg_pkg::cfg_data_t wb_dat_r,
    output glb_cfg_pkg::cfg_req_t  cfg_req,
    input  glb_cfg_pkg::cfg_rsp_t  cfg_rsp
);

    typedef enum logic [1:0] {
        ST_IDLE,
        ST_WR_ACK,
        ST_RD_WAIT,
        ST_RD_ACK
    } state_t;

    state_t                 state;
    glb_cfg_pkg::tile_id_t  adr_tile;
    logic                   in_range;
    logic                   bus_req;
    glb_cfg_pkg::cfg_data_t rd_data_q;

    assign adr_tile = wb_adr[glb_cfg_pkg::TILE_ID_LSB +: glb_cfg_pkg::TILE_ID_WIDTH];
    assign in_range = int'(adr_tile) < NUM_TILES;
    assign bus_req = wb_cyc && wb_stb;

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            state <= ST_IDLE;
            cfg_req <= '0;
            rd_data_q <= '0;
        end else begin
            // request enables last a single cycle
            cfg_req.wr_en <= 1'b0;
            cfg_req.rd_en <= 1'b0;
            case (state)
                ST_IDLE: begin
                    if (bus_req) begin
                        if (wb_we) begin
                            // writes past the last tile are dropped here
                            cfg_req.wr_en <= in_range;
                            cfg_req.wr_addr <= wb_adr;
                            cfg_req.wr_data <= wb_dat_w;
                            state <= ST_WR_ACK;
                        end else if (in_range) begin
                            cfg_req.rd_en <= 1'b1;
                            cfg_req.rd_addr <= wb_adr;
                            state <= ST_RD_WAIT;
                        end else begin
                            // no tile would answer, reply zero locally
                            rd_data_q <= '0;
                            state <= ST_RD_ACK;
                        end
                    end
                end
                ST_WR_ACK: begin
                    state <= ST_IDLE;
                end
                ST_RD_WAIT: begin
                    if (cfg_rsp.rd_data_valid) begin
                        rd_data_q <= cfg_rsp.rd_data;
                        state <= ST_RD_ACK;
                    end
                end
                ST_RD_ACK: begin
                    state <= ST_IDLE;
                end
                default: begin
                    state <= ST_IDLE;
                end
            endcase
        end
    end

    assign wb_ack = (state == ST_WR_ACK) || (state == ST_RD_ACK);
    assign wb_dat_r = rd_data_q;

    ack_inside_cycle: assert property (@(posedge clk) disable iff (reset)
        wb_ack |-> (wb_cyc && wb_stb));

    // the chain only replies to the one read in flight
    rsp_only_while_waiting: assert property (@(posedge clk) disable iff (reset)
        cfg_rsp.rd_data_valid |-> (state == ST_RD_WAIT));

endmodule

`default_nettype wire

//--- source/glb_tile_cfg.sv
// tile configuration registers and router
`timescale 1ns/100ps
`default_nettype none

module glb_tile_cfg #(
    parameter int QUEUE_DEPTH = 4,
    localparam int IDX_WIDTH = (QUEUE_DEPTH > 1) ? $clog2(QUEUE_DEPTH) : 1
) (
    input  logic                     clk,
    input  logic                     reset,
    input  glb_cfg_pkg::tile_id_t    tile_id,
    input  glb_cfg_pkg::cfg_req_t    cfg_req_est,
    output glb_cfg_pkg::cfg_rsp_t    cfg_rsp_est,
    output glb_cfg_pkg::cfg_req_t    cfg_req_wst,
    input  glb_cfg_pkg::cfg_rsp_t    cfg_rsp_wst,
    output glb_cfg_pkg::dma_header_t headers [QUEUE_DEPTH],
    output logic                     store_dma_on,
    output logic                     store_dma_auto_on,
    input  logic                     hdr_done,
    input  logic [IDX_WIDTH-1:0]     hdr_done_idx
);

    localparam int NUM_HDR_REGS = 2 * QUEUE_DEPTH;
    localparam int RW = glb_cfg_pkg::REG_IDX_WIDTH;

    logic                   wr_match;
    logic                   rd_match;
    logic                   wr_hit;
    logic                   rd_hit;
    glb_cfg_pkg::reg_idx_t  wr_reg;
    glb_cfg_pkg::reg_idx_t  rd_reg;
    glb_cfg_pkg::reg_idx_t  wr_hdr_off;
    glb_cfg_pkg::reg_idx_t  rd_hdr_off;
    logic                   wr_hdr_hit;
    logic                   rd_hdr_hit;
    logic [QUEUE_DEPTH-1:0] wr_hdr_sel;
    glb_cfg_pkg::cfg_data_t rd_data;

    // address decode, write and read sides
    assign wr_match = cfg_req_est.wr_addr[glb_cfg_pkg::TILE_ID_LSB +: glb_cfg_pkg::TILE_ID_WIDTH]
                      == tile_id;
    assign rd_match = cfg_req_est.rd_addr[glb_cfg_pkg::TILE_ID_LSB +: glb_cfg_pkg::TILE_ID_WIDTH]
                      == tile_id;
    assign wr_hit = cfg_req_est.wr_en && wr_match;
    assign rd_hit = cfg_req_est.rd_en && rd_match;

    assign wr_reg = cfg_req_est.wr_addr[glb_cfg_pkg::REG_IDX_LSB +: RW];
    assign rd_reg = cfg_req_est.rd_addr[glb_cfg_pkg::REG_IDX_LSB +: RW];
    assign wr_hdr_off = wr_reg - glb_cfg_pkg::REG_HEADER_BASE;
    assign rd_hdr_off = rd_reg - glb_cfg_pkg::REG_HEADER_BASE;
    assign wr_hdr_hit = (wr_reg >= glb_cfg_pkg::REG_HEADER_BASE) && (int'(wr_hdr_off) < NUM_HDR_REGS);
    assign rd_hdr_hit = (rd_reg >= glb_cfg_pkg::REG_HEADER_BASE) && (int'(rd_hdr_off) < NUM_HDR_REGS);

    // header q owns offsets 2q and 2q+1
    always_comb begin
        for (int q = 0; q < QUEUE_DEPTH; q++) begin
            wr_hdr_sel[q] = wr_hit && wr_hdr_hit && (int'(wr_hdr_off[RW-1:1]) == q);
        end
    end

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            store_dma_on <= 1'b0;
            store_dma_auto_on <= 1'b0;
            for (int q = 0; q < QUEUE_DEPTH; q++) begin
                headers[q] <= '0;
            end
        end else begin
            if (wr_hit && (wr_reg == glb_cfg_pkg::REG_CTRL)) begin
                {store_dma_auto_on, store_dma_on} <= cfg_req_est.wr_data[1:0];
            end
            for (int q = 0; q < QUEUE_DEPTH; q++) begin
                if (wr_hdr_sel[q] && !wr_hdr_off[0]) begin
                    {headers[q].start_addr, headers[q].valid} <=
                        cfg_req_est.wr_data[glb_cfg_pkg::GLB_ADDR_WIDTH:0];
                end else if (hdr_done && (int'(hdr_done_idx) == q)) begin
                    // finished header retires unless the host rewrites it
                    headers[q].valid <= 1'b0;
                end
                if (wr_hdr_sel[q] && wr_hdr_off[0]) begin
                    headers[q].num_words <=
                        cfg_req_est.wr_data[glb_cfg_pkg::MAX_NUM_WORDS_WIDTH-1:0];
                end
            end
        end
    end

    // read mux, unmapped indices give zero
    always_comb begin
        rd_data = '0;
        if (rd_reg == glb_cfg_pkg::REG_CTRL) begin
            rd_data[1:0] = {store_dma_auto_on, store_dma_on};
        end else if (rd_hdr_hit) begin
            for (int q = 0; q < QUEUE_DEPTH; q++) begin
                if (int'(rd_hdr_off[RW-1:1]) == q) begin
                    if (!rd_hdr_off[0]) begin
                        rd_data[glb_cfg_pkg::GLB_ADDR_WIDTH:0] =
                            {headers[q].start_addr, headers[q].valid};
                    end else begin
                        rd_data[glb_cfg_pkg::MAX_NUM_WORDS_WIDTH-1:0] = headers[q].num_words;
                    end
                end
            end
        end
    end

    // requests for other tiles move one tile west per cycle
    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            cfg_req_wst <= '0;
            cfg_rsp_est <= '0;
        end else begin
            cfg_req_wst.wr_en <= cfg_req_est.wr_en && !wr_match;
            cfg_req_wst.wr_addr <= cfg_req_est.wr_addr;
            cfg_req_wst.wr_data <= cfg_req_est.wr_data;
            cfg_req_wst.rd_en <= cfg_req_est.rd_en && !rd_match;
            cfg_req_wst.rd_addr <= cfg_req_est.rd_addr;

            // own reply, otherwise relay whatever comes from the west
            if (rd_hit) begin
                cfg_rsp_est.rd_data_valid <= 1'b1;
                cfg_rsp_est.rd_data <= rd_data;
            end else begin
                cfg_rsp_est <= cfg_rsp_wst;
            end
        end
    end

    // single outstanding read on the whole chain
    no_reply_collision: assert property (@(posedge clk) disable iff (reset)
        !(rd_hit && cfg_rsp_wst.rd_data_valid));

endmodule

`default_nettype wire

//--- source/glb_tile_store_dma.sv
// tile store dma
`timescale 1ns/100ps
`default_nettype none

module glb_tile_store_dma #(
    parameter int QUEUE_DEPTH = 4,
    localparam int IDX_WIDTH = (QUEUE_DEPTH > 1) ? $clog2(QUEUE_DEPTH) : 1
) (
    input  logic                     clk,
    input  logic                     reset,
    input  glb_cfg_pkg::dma_header_t headers [QUEUE_DEPTH],
    input  logic                     store_dma_on,
    input  logic                     store_dma_auto_on,
    input  glb_cfg_pkg::stream_t     stream_in,
    output logic                     stream_ready,
    output glb_cfg_pkg::bank_wr_t    bank_wr,
    output logic                     hdr_done,
    output logic [IDX_WIDTH-1:0]     hdr_done_idx
);

    typedef enum logic [1:0] {
        ST_IDLE,
        ST_SCAN,
        ST_XFER
    } state_t;

    state_t                   state;
    logic [IDX_WIDTH-1:0]     ptr;
    logic [IDX_WIDTH-1:0]     ptr_next;
    glb_cfg_pkg::num_words_t  count;
    glb_cfg_pkg::dma_header_t cur;
    logic                     accept;
    logic                     last_word;
    logic                     finish;

    assign cur = headers[ptr];
    assign ptr_next = (int'(ptr) == QUEUE_DEPTH - 1) ? '0 : ptr + 1'b1;

    assign stream_ready = (state == ST_XFER) && store_dma_on;
    assign accept = stream_in.valid && stream_ready;
    assign last_word = (count + 1'b1) >= cur.num_words;

    // empty header finishes straight from the scan
    assign finish = (state == ST_SCAN && store_dma_on && cur.valid && cur.num_words == '0)
                    || (accept && last_word);

    // auto mode keeps headers, so no retire request
    assign hdr_done = finish && !store_dma_auto_on;
    assign hdr_done_idx = ptr;

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            state <= ST_IDLE;
            ptr <= '0;
            count <= '0;
            bank_wr <= '0;
        end else begin
            bank_wr.en <= accept;
            if (accept) begin
                bank_wr.addr <= cur.start_addr + glb_cfg_pkg::glb_addr_t'(count);
                bank_wr.data <= stream_in.data;
            end

            case (state)
                ST_IDLE: begin
                    if (store_dma_on) begin
                        state <= ST_SCAN;
                    end
                end
                ST_SCAN: begin
                    if (!store_dma_on) begin
                        state <= ST_IDLE;
                    end else if (!cur.valid || cur.num_words == '0) begin
                        // one header per cycle
                        ptr <= ptr_next;
                        count <= '0;
                    end else begin
                        state <= ST_XFER;
                    end
                end
                ST_XFER: begin
                    if (accept) begin
                        if (last_word) begin
                            count <= '0;
                            ptr <= ptr_next;
                            state <= ST_SCAN;
                        end else begin
                            count <= count + 1'b1;
                        end
                    end else if (!store_dma_on) begin
                        // count kept, a later scan resumes this header
                        state <= ST_IDLE;
                    end
                end
                default: begin
                    state <= ST_IDLE;
                end
            endcase
        end
    end

    // word count stays inside the active header
    count_within_header: assert property (@(posedge clk) disable iff (reset)
        (state == ST_XFER) |-> (count < cur.num_words));

endmodule

`default_nettype wire

//--- source/glb_tile.sv
// global buffer tile
`timescale 1ns/100ps
`default_nettype none

module glb_tile #(
    parameter int QUEUE_DEPTH = 4,
    localparam int IDX_WIDTH = (QUEUE_DEPTH > 1) ? $clog2(QUEUE_DEPTH) : 1
) (
    input  logic                  clk,
    input  logic                  reset,
    input  glb_cfg_pkg::tile_id_t tile_id,
    input  glb_cfg_pkg::cfg_req_t cfg_req_est,
    output glb_cfg_pkg::cfg_rsp_t cfg_rsp_est,
    output glb_cfg_pkg::cfg_req_t cfg_req_wst,
    input  glb_cfg_pkg::cfg_rsp_t cfg_rsp_wst,
    input  glb_cfg_pkg::stream_t  stream_in,
    output logic                  stream_ready,
    output glb_cfg_pkg::bank_wr_t bank_wr
);

    // configuration to dma
    glb_cfg_pkg::dma_header_t headers [QUEUE_DEPTH];
    logic                     store_dma_on;
    logic                     store_dma_auto_on;
    logic                     hdr_done;
    logic [IDX_WIDTH-1:0]     hdr_done_idx;

    glb_tile_cfg #(
        .QUEUE_DEPTH(QUEUE_DEPTH)
    ) u_cfg (
        .clk              (clk),
        .reset            (reset),
        .tile_id          (tile_id),
        .cfg_req_est      (cfg_req_est),
        .cfg_rsp_est      (cfg_rsp_est),
        .cfg_req_wst      (cfg_req_wst),
        .cfg_rsp_wst      (cfg_rsp_wst),
        .headers          (headers),
        .store_dma_on     (store_dma_on),
        .store_dma_auto_on(store_dma_auto_on),
        .hdr_done         (hdr_done),
        .hdr_done_idx     (hdr_done_idx)
    );

    glb_tile_store_dma #(
        .QUEUE_DEPTH(QUEUE_DEPTH)
    ) u_store_dma (
        .clk              (clk),
        .reset            (reset),
        .headers          (headers),
        .store_dma_on     (store_dma_on),
        .store_dma_auto_on(store_dma_auto_on),
        .stream_in        (stream_in),
        .stream_ready     (stream_ready),
        .bank_wr          (bank_wr),
        .hdr_done         (hdr_done),
        .hdr_done_idx     (hdr_done_idx)
    );

endmodule

`default_nettype wire

//--- source/glb_cfg_top.sv
// global buffer configuration top
`timescale 1ns/100ps
`default_nettype none

module glb_cfg_top #(
    parameter int NUM_TILES = 4,
    parameter int QUEUE_DEPTH = 4
) (
    input  logic                   clk,
    input  logic                   reset,
    input  logic                   wb_cyc,
    input  logic                   wb_stb,
    input  logic                   wb_we,
    input  glb_cfg_pkg::cfg_addr_t wb_adr,
    input  glb_cfg_pkg::cfg_data_t wb_dat_w,
    output logic                   wb_ack,
    output glb_cfg_pkg::cfg_data_t wb_dat_r,
    input  glb_cfg_pkg::stream_t   stream_in [NUM_TILES],
    output logic [NUM_TILES-1:0]   stream_ready,
    output glb_cfg_pkg::bank_wr_t  bank_wr [NUM_TILES]
);

    // chain links, index k sits on the east side of tile k
    glb_cfg_pkg::cfg_req_t req_chain [NUM_TILES+1];
    glb_cfg_pkg::cfg_rsp_t rsp_chain [NUM_TILES+1];

    glb_cfg_wb_bridge #(
        .NUM_TILES(NUM_TILES)
    ) u_bridge (
        .clk     (clk),
        .reset   (reset),
        .wb_cyc  (wb_cyc),
        .wb_stb  (wb_stb),
        .wb_we   (wb_we),
        .wb_adr  (wb_adr),
        .wb_dat_w(wb_dat_w),
        .wb_ack  (wb_ack),
        .wb_dat_r(wb_dat_r),
        .cfg_req (req_chain[0]),
        .cfg_rsp (rsp_chain[0])
    );

    // nothing replies from beyond the west end
    assign rsp_chain[NUM_TILES] = '0;

    for (genvar k = 0; k < NUM_TILES; k++) begin : g_tile
        glb_tile #(
            .QUEUE_DEPTH(QUEUE_DEPTH)
        ) u_tile (
            .clk         (clk),
            .reset       (reset),
            .tile_id     (glb_cfg_pkg::tile_id_t'(k)),
            .cfg_req_est (req_chain[k]),
            .cfg_rsp_est (rsp_chain[k]),
            .cfg_req_wst (req_chain[k+1]),
            .cfg_rsp_wst (rsp_chain[k+1]),
            .stream_in   (stream_in[k]),
            .stream_ready(stream_ready[k]),
            .bank_wr     (bank_wr[k])
        );
    end

endmodule

`default_nettype wire

//--- verif/glb_cfg_tests.svh
// directed configuration and dma tests
`ifndef GLB_CFG_TESTS_SVH
`define GLB_CFG_TESTS_SVH

// all tiles, all registers, plus one unmapped index
task automatic all_registers_zero();
    for (int t = 0; t < NUM_TILES; t++) begin
        for (int r = 0; r <= NUM_REGS; r++) begin
            read_expect(t, r, '0);
        end
    end
endtask

task automatic reset_values_zero();
    all_registers_zero();
    check_value("stream_ready", glb_cfg_pkg::cfg_data_t'(stream_ready), '0);
    check_value("bank write count", bank_log.size(), 0);
endtask

task automatic register_readback();
    glb_cfg_pkg::cfg_data_t written [NUM_TILES][NUM_REGS+1];
    for (int t = 0; t < NUM_TILES; t++) begin
        for (int r = 0; r <= NUM_REGS; r++) begin
            written[t][r] = 32'h9e37_79b9 * glb_cfg_pkg::cfg_data_t'(t * 16 + r + 1);
            // dma kept off, a running dma would retire empty headers
            if (r == 0) begin
                written[t][r][0] = 1'b0;
                // auto bit differs between neighbouring tiles
                written[t][r][1] = t[0];
            end
            wb_write(reg_addr(t, r), written[t][r]);
        end
    end
    // all writes first, so a leak into another tile shows up
    for (int t = 0; t < NUM_TILES; t++) begin
        for (int r = 0; r <= NUM_REGS; r++) begin
            read_expect(t, r, written[t][r] & reg_mask(r));
        end
    end
    clear_registers();
endtask

task automatic out_of_range_access();
    // leave nonzero read data in the bridge first
    wb_write(reg_addr(0, 1), 32'h0000_5a5b);
    read_expect(0, 1, 32'h0000_5a5b);
    read_expect(NUM_TILES, 1, '0);
    read_expect(NUM_TILES, 0, '0);
    wb_write(reg_addr(0, 1), '0);
    wb_write(reg_addr(NUM_TILES, 1), 32'hffff_ffff);
    wb_write(reg_addr(NUM_TILES, 0), 32'h0000_0003);
    all_registers_zero();
endtask

task automatic single_header_store();
    glb_cfg_pkg::bank_data_t words [$];
    bank_rec_t expected [$];
    glb_cfg_pkg::glb_addr_t start;
    start = 16'h0120;
    program_header(1, 0, start, 6);
    wb_write(reg_addr(1, 0), 32'h0000_0001);
    for (int i = 0; i < 6; i++) begin
        words.push_back($urandom());
        expected.push_back(make_rec(1, start + glb_cfg_pkg::glb_addr_t'(i), words[i]));
    end
    send_words(1, words);
    expect_bank_writes(expected);
    // finished header has retired
    read_expect(1, 1, glb_cfg_pkg::cfg_data_t'({start, 1'b0}));
    wb_write(reg_addr(1, 0), '0);
endtask

task automatic auto_mode_store();
    glb_cfg_pkg::bank_data_t words [$];
    bank_rec_t expected [$];
    glb_cfg_pkg::glb_addr_t start_0;
    glb_cfg_pkg::glb_addr_t start_2;
    start_0 = 16'h0200;
    start_2 = 16'h0400;
    program_header(2, 0, start_0, 3);
    program_header(2, 2, start_2, 2);
    wb_write(reg_addr(2, 0), 32'h0000_0003);
    for (int i = 0; i < 8; i++) begin
        words.push_back($urandom());
    end
    // header 0, header 2, then header 0 again
    for (int i = 0; i < 3; i++) begin
        expected.push_back(make_rec(2, start_0 + glb_cfg_pkg::glb_addr_t'(i), words[i]));
    end
    for (int i = 0; i < 2; i++) begin
        expected.push_back(make_rec(2, start_2 + glb_cfg_pkg::glb_addr_t'(i), words[3 + i]));
    end
    for (int i = 0; i < 3; i++) begin
        expected.push_back(make_rec(2, start_0 + glb_cfg_pkg::glb_addr_t'(i), words[5 + i]));
    end
    send_words(2, words);
    expect_bank_writes(expected);
    read_expect(2, 1, glb_cfg_pkg::cfg_data_t'({start_0, 1'b1}));
    read_expect(2, 5, glb_cfg_pkg::cfg_data_t'({start_2, 1'b1}));
    wb_write(reg_addr(2, 0), '0);
endtask

task automatic dma_off_backpressure();
    glb_cfg_pkg::bank_data_t words [$];
    bank_rec_t expected [$];
    glb_cfg_pkg::glb_addr_t start;
    start = 16'h0300;
    program_header(3, 1, start, 4);
    for (int i = 0; i < 4; i++) begin
        words.push_back($urandom());
        expected.push_back(make_rec(3, start + glb_cfg_pkg::glb_addr_t'(i), words[i]));
    end
    // word offered while the dma is still off
    @(posedge clk);
    stream_in[3].valid <= 1'b1;
    stream_in[3].data <= words[0];
    for (int c = 0; c < OFF_WAIT_CYCLES; c++) begin
        @(negedge clk);
        check_value("stream_ready[3]", stream_ready[3], 1'b0);
    end
    check_value("bank write count", bank_log.size(), 0);
    @(posedge clk);
    stream_in[3].valid <= 1'b0;
    wb_write(reg_addr(3, 0), 32'h0000_0001);
    send_words(3, words);
    expect_bank_writes(expected);
    read_expect(3, 3, glb_cfg_pkg::cfg_data_t'({start, 1'b0}));
    wb_write(reg_addr(3, 0), '0);
endtask

`endif

//--- verif/glb_cfg_tb.sv
// configuration chain testbench
`timescale 1ns/100ps
`default_nettype none

module glb_cfg_tb;

    localparam int NUM_TILES = 4;
    localparam int QUEUE_DEPTH = 4;
    // control register plus two words per header
    localparam int NUM_REGS = 1 + 2 * QUEUE_DEPTH;
    localparam int ACK_TIMEOUT = 100;
    localparam int STREAM_TIMEOUT = 200;
    localparam int OFF_WAIT_CYCLES = 40;
    localparam logic [31:0] RAND_SEED = 32'h0d82_8756;

    typedef struct packed {
        glb_cfg_pkg::tile_id_t   tile;
        glb_cfg_pkg::glb_addr_t  addr;
        glb_cfg_pkg::bank_data_t data;
    } bank_rec_t;

    logic                   clk;
    logic                   reset;
    logic                   wb_cyc;
    logic                   wb_stb;
    logic                   wb_we;
    glb_cfg_pkg::cfg_addr_t wb_adr;
    glb_cfg_pkg::cfg_data_t wb_dat_w;
    logic                   wb_ack;
    glb_cfg_pkg::cfg_data_t wb_dat_r;
    glb_cfg_pkg::stream_t   stream_in [NUM_TILES];
    logic [NUM_TILES-1:0]   stream_ready;
    glb_cfg_pkg::bank_wr_t  bank_wr [NUM_TILES];

    // every bank write of every tile, in arrival order
    bank_rec_t bank_log [$];

    glb_cfg_top #(
        .NUM_TILES  (NUM_TILES),
        .QUEUE_DEPTH(QUEUE_DEPTH)
    ) glb_cfg_top_inst (
        .clk         (clk),
        .reset       (reset),
        .wb_cyc      (wb_cyc),
        .wb_stb      (wb_stb),
        .wb_we       (wb_we),
        .wb_adr      (wb_adr),
        .wb_dat_w    (wb_dat_w),
        .wb_ack      (wb_ack),
        .wb_dat_r    (wb_dat_r),
        .stream_in   (stream_in),
        .stream_ready(stream_ready),
        .bank_wr     (bank_wr)
    );

    initial begin
        clk = 1'b0;
        forever #4 clk = ~clk;
    end

    always @(negedge clk) begin
        for (int k = 0; k < NUM_TILES; k++) begin
            if (bank_wr[k].en) begin
                bank_log.push_back(make_rec(k, bank_wr[k].addr, bank_wr[k].data));
            end
        end
    end

    task automatic stop_run(input string reason);
        $display("%s", reason);
        $display("TEST FAILED");
        $fatal(1, "simulation stopped");
    endtask

    task automatic check_value(input string name, input logic [31:0] actual,
                               input logic [31:0] expected);
        if (actual !== expected) begin
            stop_run($sformatf("Error at time %0t: %s is %h, expected %h",
                               $time, name, actual, expected));
        end
    endtask

    // tile id in bits 10:7, register index in bits 6:2
    function automatic glb_cfg_pkg::cfg_addr_t reg_addr(input int tile, input int idx);
        return glb_cfg_pkg::cfg_addr_t'((tile << 7) | (idx << 2));
    endfunction

    // readable bits of each register index
    function automatic glb_cfg_pkg::cfg_data_t reg_mask(input int idx);
        if (idx == 0) begin
            return 32'h0000_0003;
        end else if (idx < NUM_REGS) begin
            return (idx % 2 == 1) ? 32'h0001_ffff : 32'h0000_00ff;
        end else begin
            return '0;
        end
    endfunction

    function automatic bank_rec_t make_rec(input int tile, input glb_cfg_pkg::glb_addr_t addr,
                                           input glb_cfg_pkg::bank_data_t data);
        bank_rec_t rec;
        rec.tile = glb_cfg_pkg::tile_id_t'(tile);
        rec.addr = addr;
        rec.data = data;
        return rec;
    endfunction

    task automatic wb_write(input glb_cfg_pkg::cfg_addr_t addr,
                            input glb_cfg_pkg::cfg_data_t data);
        int cycles;
        @(posedge clk);
        wb_cyc <= 1'b1;
        wb_stb <= 1'b1;
        wb_we <= 1'b1;
        wb_adr <= addr;
        wb_dat_w <= data;
        cycles = 0;
        @(negedge clk);
        while (!wb_ack) begin
            if (cycles == ACK_TIMEOUT) begin
                stop_run($sformatf("write to address %h was never acknowledged", addr));
            end
            @(negedge clk);
            cycles++;
        end
        @(posedge clk);
        wb_cyc <= 1'b0;
        wb_stb <= 1'b0;
        wb_we <= 1'b0;
    endtask

    task automatic wb_read(input glb_cfg_pkg::cfg_addr_t addr,
                           output glb_cfg_pkg::cfg_data_t data);
        int cycles;
        @(posedge clk);
        wb_cyc <= 1'b1;
        wb_stb <= 1'b1;
        wb_we <= 1'b0;
        wb_adr <= addr;
        cycles = 0;
        @(negedge clk);
        while (!wb_ack) begin
            if (cycles == ACK_TIMEOUT) begin
                stop_run($sformatf("read from address %h was never acknowledged", addr));
            end
            @(negedge clk);
            cycles++;
        end
        data = wb_dat_r;
        @(posedge clk);
        wb_cyc <= 1'b0;
        wb_stb <= 1'b0;
    endtask

    task automatic read_expect(input int tile, input int idx,
                               input glb_cfg_pkg::cfg_data_t expected);
        glb_cfg_pkg::cfg_data_t data;
        wb_read(reg_addr(tile, idx), data);
        check_value($sformatf("wb_dat_r (tile %0d reg %0d)", tile, idx), data, expected);
    endtask

    // valid header q with its start address and word count
    task automatic program_header(input int tile, input int q,
                                  input glb_cfg_pkg::glb_addr_t start, input int num);
        wb_write(reg_addr(tile, 1 + 2 * q), glb_cfg_pkg::cfg_data_t'({start, 1'b1}));
        wb_write(reg_addr(tile, 2 + 2 * q), glb_cfg_pkg::cfg_data_t'(num));
    endtask

    task automatic clear_registers();
        for (int t = 0; t < NUM_TILES; t++) begin
            for (int r = 0; r < NUM_REGS; r++) begin
                wb_write(reg_addr(t, r), '0);
            end
        end
    endtask

    // each word is held until the edge where ready is high
    task automatic send_words(input int tile, input glb_cfg_pkg::bank_data_t words [$]);
        int cycles;
        @(posedge clk);
        foreach (words[i]) begin
            stream_in[tile].valid <= 1'b1;
            stream_in[tile].data <= words[i];
            cycles = 0;
            @(negedge clk);
            while (!stream_ready[tile]) begin
                if (cycles == STREAM_TIMEOUT) begin
                    stop_run($sformatf("tile %0d never took stream word %0d", tile, i));
                end
                @(negedge clk);
                cycles++;
            end
            @(posedge clk);
        end
        stream_in[tile].valid <= 1'b0;
    endtask

    task automatic expect_bank_writes(input bank_rec_t expected [$]);
        int cycles;
        cycles = 0;
        while (bank_log.size() < expected.size()) begin
            if (cycles == STREAM_TIMEOUT) begin
                stop_run("bank writes stopped before all words were stored");
            end
            @(negedge clk);
            cycles++;
        end
        // a few more cycles for any stray write
        repeat (4) @(negedge clk);
        check_value("bank write count", bank_log.size(), expected.size());
        foreach (expected[i]) begin
            check_value($sformatf("bank write %0d tile", i), bank_log[i].tile, expected[i].tile);
            check_value($sformatf("bank_wr.addr (write %0d)", i), bank_log[i].addr,
                        expected[i].addr);
            check_value($sformatf("bank_wr.data (write %0d)", i), bank_log[i].data,
                        expected[i].data);
        end
        bank_log.delete();
    endtask

    `include "glb_cfg_tests.svh"

    initial begin
        void'($urandom(RAND_SEED));
        reset = 1'b1;
        wb_cyc = 1'b0;
        wb_stb = 1'b0;
        wb_we = 1'b0;
        wb_adr = '0;
        wb_dat_w = '0;
        for (int k = 0; k < NUM_TILES; k++) begin
            stream_in[k] = '0;
        end
        repeat (16) @(posedge clk);
        reset <= 1'b0;
        repeat (2) @(posedge clk);

        reset_values_zero();
        register_readback();
        out_of_range_access();
        single_header_store();
        auto_mode_store();
        dma_off_backpressure();

        $display("TEST PASSED");
        $finish;
    end

endmodule

`default_nettype wire

//--- glb_cfg.f
source/glb_cfg_pkg.sv
source/glb_cfg_wb_bridge.sv
source/glb_tile_cfg.sv
source/glb_tile_store_dma.sv
source/glb_tile.sv
source/glb_cfg_top.sv
+incdir+verif
verif/glb_cfg_tb.sv

//--- Makefile
TOOL      = verilator
TOP       = glb_cfg_tb
RTL_TOP   = glb_cfg_top
FILELIST  = glb_cfg.f
FLAGS     = --binary --timing --assert -Wno-fatal
LINTFLAGS = --lint-only -Wall --timing
BUILD_DIR = obj_dir
LOG       = sim.log

.PHONY: all build run lint clean

all: run

build:
	$(TOOL) $(FLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD_DIR)

run: build
	./$(BUILD_DIR)/V$(TOP) > $(LOG) 2>&1 || true
	cat $(LOG)
	grep -q "TEST PASSED" $(LOG)

lint:
	$(TOOL) $(LINTFLAGS) --top-module $(RTL_TOP) -f $(FILELIST)

clean:
	rm -rf $(BUILD_DIR) $(LOG)
